// ==== common/msa_pkg.sv ====
`default_nettype none

package msa_pkg;

    // Link geometry
    localparam int lanes     = 4;
    localparam int spl       = 2;               // Symbols per lane
    localparam int sublanes  = lanes * spl;
    localparam int ram_words = 32;              // Rows per bank
    localparam int ram_adr_w = 5;

    // One link symbol
    typedef struct packed {
        logic       k;                          // Control symbol
        logic [7:0] dat;
    } sym_t;

    localparam sym_t sym_bs = '{k: 1'b1, dat: 8'hbc};     // K28.5
    localparam sym_t sym_bf = '{k: 1'b1, dat: 8'h7c};     // K28.3

    localparam logic [7:0] vbid_no_video = 8'h09;

    // 1 - one lane, 2 - two lanes, 3 - four lanes, 0 as one lane
    typedef logic [1:0] lane_cfg_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [7:0] paddr;                      // Symbol index
        sym_t       pwdata;
    } apb_req_t;

    typedef struct packed {
        sym_t       prdata;
        logic       pready;
        logic       pslverr;
    } apb_rsp_t;

    // Lane-major, sublane 0 of lane 0 at index 0
    typedef sym_t [sublanes-1:0] lnk_word_t;

    typedef struct packed {
        logic       vs;                         // Vsync
        logic       vbf;                        // Vertical blanking flag
        logic       bs;                         // Blanking start
    } vid_sync_t;

    typedef enum logic [1:0] {
        bs_none, bs_first, bs_second, bs_third
    } bs_phase_t;

endpackage

`default_nettype wire

// ==== msa_store/msa_apb_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module msa_apb_port
(
    input wire                                      LNK_RST_IN,
    input wire                                      LNK_CLK_IN,
    input wire msa_pkg::apb_req_t                   apb_req,
    output msa_pkg::apb_rsp_t                       apb_rsp,
    input wire msa_pkg::lane_cfg_t                  lanes,
    output logic [msa_pkg::sublanes-1:0]            wr_en,      // One strobe per bank
    output logic [msa_pkg::ram_adr_w-1:0]           wr_row,
    output msa_pkg::sym_t                           wr_sym,
    output logic [msa_pkg::ram_adr_w-1:0]           rd_row,
    output logic [$clog2(msa_pkg::sublanes)-1:0]    rd_bank,
    input wire msa_pkg::sym_t                       rd_sym
);

localparam int bank_w = $clog2(msa_pkg::sublanes);

logic [7:0]         row_full;   // Index divided by active sublanes
logic [bank_w-1:0]  bank;
logic               oor;        // Index beyond the bank depth
logic               setup;
logic               access;
logic               slverr_q;

assign setup  = apb_req.psel && !apb_req.penable;
assign access = apb_req.psel && apb_req.penable;

// Index decode, the sublane number is the bank number
always_comb
begin
    case (lanes)
        2'd3 :
        begin
            row_full = {3'b000, apb_req.paddr[7:3]};
            bank     = apb_req.paddr[2:0];
        end
        2'd2 :
        begin
            row_full = {2'b00, apb_req.paddr[7:2]};
            bank     = {1'b0, apb_req.paddr[1:0]};
        end
        default :                                   // One lane
        begin
            row_full = {1'b0, apb_req.paddr[7:1]};
            bank     = {2'b00, apb_req.paddr[0]};
        end
    endcase
end

assign oor = |row_full[7:msa_pkg::ram_adr_w];

// Bank write strobes
always_comb
begin
    wr_en = '0;
    if (access && apb_req.pwrite && !oor)
        wr_en[bank] = 1'b1;
end

assign wr_row  = row_full[msa_pkg::ram_adr_w-1:0];
assign wr_sym  = apb_req.pwdata;
assign rd_row  = row_full[msa_pkg::ram_adr_w-1:0];
assign rd_bank = bank;

// Error flag decided in setup, shown in access
always_ff @(posedge LNK_RST_IN, posedge LNK_CLK_IN)
begin
    if (LNK_RST_IN)
        slverr_q <= 1'b0;
    else
        slverr_q <= setup && oor;
end

always_comb
begin
    apb_rsp.prdata  = (access && !apb_req.pwrite && !oor) ? rd_sym : '0;
    apb_rsp.pready  = 1'b1;                         // Zero wait
    apb_rsp.pslverr = slverr_q;
end

// Every access cycle follows a setup cycle
a_apb_setup_first : assert property (
    @(posedge LNK_CLK_IN) disable iff (LNK_RST_IN)
    apb_req.penable |-> apb_req.psel && $past(setup)
) else $error("APB access without psel or setup phase");

endmodule

`default_nettype wire

// ==== msa_store/msa_symbol_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module msa_symbol_ram
(
    input wire                                      LNK_CLK_IN,
    input wire                                      LNK_RST_IN,
    input wire msa_pkg::lane_cfg_t                  lanes,
    input wire [msa_pkg::sublanes-1:0]              wr_en,
    input wire [msa_pkg::ram_adr_w-1:0]             wr_row,
    input wire msa_pkg::sym_t                       wr_sym,
    input wire [msa_pkg::ram_adr_w-1:0]             rd_row,
    input wire [$clog2(msa_pkg::sublanes)-1:0]      rd_bank,
    output msa_pkg::sym_t                           rd_sym,
    input wire                                      vs_start,
    output msa_pkg::lnk_word_t                      msa_word,
    output logic                                    msa_de
);

// MSA rows per frame for each lane count
localparam int rows_4l = 6;
localparam int rows_2l = 11;
localparam int rows_1l = 20;

msa_pkg::sym_t                  mem [msa_pkg::sublanes][msa_pkg::ram_words];
logic [msa_pkg::ram_adr_w-1:0]  rp;         // Read pointer
logic [msa_pkg::ram_adr_w-1:0]  rd_cnt;     // Rows left
logic                           rd;

assign rd = (rd_cnt != '0);

// Banks, written from APB and read row by row
always_ff @(posedge LNK_CLK_IN)
begin
    for (int b = 0; b < msa_pkg::sublanes; b++)
    begin
        if (wr_en[b])
            mem[b][wr_row] <= wr_sym;
        if (rd)
            msa_word[b] <= mem[b][rp];
    end
end

// APB read path
assign rd_sym = mem[rd_bank][rd_row];

// Read-out control
always_ff @(posedge LNK_RST_IN, posedge LNK_CLK_IN)
begin
    if (LNK_RST_IN)
    begin
        rd_cnt <= '0;
        rp     <= '0;
        msa_de <= 1'b0;
    end
    else
    begin
        msa_de <= rd;

        if (vs_start)
        begin
            rp <= '0;
            case (lanes)
                2'd3    : rd_cnt <= msa_pkg::ram_adr_w'(rows_4l);
                2'd2    : rd_cnt <= msa_pkg::ram_adr_w'(rows_2l);
                default : rd_cnt <= msa_pkg::ram_adr_w'(rows_1l);
            endcase
        end
        else if (rd)
        begin
            rp     <= rp + 1'b1;
            rd_cnt <= rd_cnt - 1'b1;
        end
    end
end

// A new vsync edge only comes once the row counter has run out
a_row_cnt_idle : assert property (
    @(posedge LNK_CLK_IN) disable iff (LNK_RST_IN)
    vs_start |-> rd_cnt == '0
) else $error("Vsync edge during MSA read-out");

endmodule

`default_nettype wire

// ==== src/blank_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module blank_sequencer
#(
    parameter int P_IDLE_PERIOD = 8192      // In symbols
)
(
    input wire                          LNK_RST_IN,
    input wire                          LNK_CLK_IN,
    input wire                          vid_en,
    input wire                          efm_in,
    input wire msa_pkg::vid_sync_t      sync,
    output logic                        vs_start,   // Vsync rising edge
    output logic                        run,
    output logic                        vbf,
    output logic                        efm,
    output msa_pkg::bs_phase_t          bs_phase
);

localparam int cnt_w    = $clog2(P_IDLE_PERIOD) + 1;
localparam int idle_max = P_IDLE_PERIOD - msa_pkg::spl;

msa_pkg::vid_sync_t     sync_r;
logic                   vs_d;
logic                   en_r;
logic [cnt_w-1:0]       idle_cnt;
logic                   idle_start;

// Input registers
always_ff @(posedge LNK_RST_IN, posedge LNK_CLK_IN)
begin
    if (LNK_RST_IN)
    begin
        sync_r <= '0;
        vs_d   <= 1'b0;
        en_r   <= 1'b0;
        efm    <= 1'b0;
    end
    else
    begin
        sync_r <= sync;
        vs_d   <= sync_r.vs;
        en_r   <= vid_en;
        efm    <= efm_in;
    end
end

assign vs_start = sync_r.vs && !vs_d;
assign vbf      = sync_r.vbf;

// Run flag, set at vsync and dropped with the enable
always_ff @(posedge LNK_RST_IN, posedge LNK_CLK_IN)
begin
    if (LNK_RST_IN)
        run <= 1'b0;
    else if (!en_r)
        run <= 1'b0;
    else if (vs_start)
        run <= 1'b1;
end

// Idle counter, two symbols per link cycle
always_ff @(posedge LNK_RST_IN, posedge LNK_CLK_IN)
begin
    if (LNK_RST_IN)
    begin
        idle_cnt   <= '0;
        idle_start <= 1'b0;
    end
    else
    begin
        idle_start <= 1'b0;
        if (run)
            idle_cnt <= '0;
        else if (idle_cnt >= cnt_w'(idle_max))
        begin
            idle_cnt   <= '0;
            idle_start <= 1'b1;
        end
        else
            idle_cnt <= idle_cnt + cnt_w'(msa_pkg::spl);
    end
end

// BS phases, two in normal framing and three in enhanced
always_ff @(posedge LNK_RST_IN, posedge LNK_CLK_IN)
begin
    if (LNK_RST_IN)
        bs_phase <= msa_pkg::bs_none;
    else if (idle_start || sync_r.bs)
        bs_phase <= msa_pkg::bs_first;
    else
    begin
        case (bs_phase)
            msa_pkg::bs_first  : bs_phase <= msa_pkg::bs_second;
            msa_pkg::bs_second : bs_phase <= efm ? msa_pkg::bs_third : msa_pkg::bs_none;
            default            : bs_phase <= msa_pkg::bs_none;
        endcase
    end
end

// Once video has been running for a cycle no idle sequence may start
a_no_idle_in_run : assert property (
    @(posedge LNK_CLK_IN) disable iff (LNK_RST_IN)
    run && $past(run) |-> !idle_start
) else $error("Idle BS sequence started while video running");

endmodule

`default_nettype wire

// ==== src/lane_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_mux
(
    input wire                          LNK_CLK_IN,
    input wire msa_pkg::lnk_word_t      msa_word,
    input wire                          msa_de,
    input wire msa_pkg::bs_phase_t      bs_phase,
    input wire                          efm,
    input wire                          run,
    input wire                          vbf,
    input wire msa_pkg::lnk_word_t      lnk_in,
    output msa_pkg::lnk_word_t          lnk_out
);

logic [7:0]             vbid;
msa_pkg::sym_t          bs_sym0;    // Symbol position 0 of each lane
msa_pkg::sym_t          bs_sym1;    // Symbol position 1 of each lane
msa_pkg::lnk_word_t     bs_word;

assign vbid = run ? {7'h00, vbf} : msa_pkg::vbid_no_video;

// BS sequence symbols for the current phase
always_comb
begin
    bs_sym0 = '0;
    bs_sym1 = '0;

    if (efm)
    begin
        case (bs_phase)
            msa_pkg::bs_first :
            begin
                bs_sym0 = msa_pkg::sym_bs;
                bs_sym1 = msa_pkg::sym_bf;
            end
            msa_pkg::bs_second :
            begin
                bs_sym0 = msa_pkg::sym_bf;
                bs_sym1 = msa_pkg::sym_bs;
            end
            msa_pkg::bs_third :
                bs_sym0 = '{k: 1'b0, dat: vbid};    // Mvid slot stays zero
            default : ;
        endcase
    end
    else if (bs_phase == msa_pkg::bs_first)     // Normal framing, second phase all zero
    begin
        bs_sym0 = msa_pkg::sym_bs;
        bs_sym1 = '{k: 1'b0, dat: vbid};
    end
end

// Same pair on every lane
always_comb
begin
    for (int l = 0; l < msa_pkg::lanes; l++)
    begin
        bs_word[l * msa_pkg::spl]     = bs_sym0;
        bs_word[l * msa_pkg::spl + 1] = bs_sym1;
    end
end

// Output register, MSA before BS before pass-through
always_ff @(posedge LNK_CLK_IN)
begin
    if (msa_de)
        lnk_out <= msa_word;
    else if (bs_phase != msa_pkg::bs_none)
        lnk_out <= bs_word;
    else
        lnk_out <= lnk_in;
end

endmodule

`default_nettype wire

// ==== src/msa_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module msa_top
#(
    parameter int P_IDLE_PERIOD = 8192      // Idle BS interval in symbols
)
(
    input wire                          LNK_RST_IN,
    input wire                          LNK_CLK_IN,
    input wire msa_pkg::lane_cfg_t      lanes,
    input wire                          vid_en,
    input wire                          efm,
    input wire msa_pkg::vid_sync_t      sync,
    input wire msa_pkg::apb_req_t       apb_req,
    output msa_pkg::apb_rsp_t           apb_rsp,
    input wire msa_pkg::lnk_word_t      lnk_in,
    output msa_pkg::lnk_word_t          lnk_out
);

// Port to RAM
logic [msa_pkg::sublanes-1:0]           wr_en;
logic [msa_pkg::ram_adr_w-1:0]          wr_row;
msa_pkg::sym_t                          wr_sym;
logic [msa_pkg::ram_adr_w-1:0]          rd_row;
logic [$clog2(msa_pkg::sublanes)-1:0]   rd_bank;
msa_pkg::sym_t                          rd_sym;

// Read-out and blanking
msa_pkg::lnk_word_t                     msa_word;
logic                                   msa_de;
logic                                   vs_start;
logic                                   run;
logic                                   vbf;
logic                                   efm_r;
msa_pkg::bs_phase_t                     bs_phase;

msa_apb_port i_msa_apb_port
(
    .LNK_RST_IN (LNK_RST_IN),
    .LNK_CLK_IN (LNK_CLK_IN),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .lanes      (lanes),
    .wr_en      (wr_en),
    .wr_row     (wr_row),
    .wr_sym     (wr_sym),
    .rd_row     (rd_row),
    .rd_bank    (rd_bank),
    .rd_sym     (rd_sym)
);

msa_symbol_ram i_msa_symbol_ram
(
    .LNK_CLK_IN (LNK_CLK_IN),
    .LNK_RST_IN (LNK_RST_IN),
    .lanes      (lanes),
    .wr_en      (wr_en),
    .wr_row     (wr_row),
    .wr_sym     (wr_sym),
    .rd_row     (rd_row),
    .rd_bank    (rd_bank),
    .rd_sym     (rd_sym),
    .vs_start   (vs_start),
    .msa_word   (msa_word),
    .msa_de     (msa_de)
);

blank_sequencer #(.P_IDLE_PERIOD (P_IDLE_PERIOD)) i_blank_sequencer
(
    .LNK_RST_IN (LNK_RST_IN),
    .LNK_CLK_IN (LNK_CLK_IN),
    .vid_en     (vid_en),
    .efm_in     (efm),
    .sync       (sync),
    .vs_start   (vs_start),
    .run        (run),
    .vbf        (vbf),
    .efm        (efm_r),
    .bs_phase   (bs_phase)
);

lane_mux i_lane_mux
(
    .LNK_CLK_IN (LNK_CLK_IN),
    .msa_word   (msa_word),
    .msa_de     (msa_de),
    .bs_phase   (bs_phase),
    .efm        (efm_r),
    .run        (run),
    .vbf        (vbf),
    .lnk_in     (lnk_in),
    .lnk_out    (lnk_out)
);

endmodule

`default_nettype wire

// ==== verif/msa_tb_tests.svh ====
task automatic set_lanes(input msa_pkg::lane_cfg_t code);
    @(posedge LNK_CLK_IN);
    lanes <= code;
    @(posedge LNK_CLK_IN);
endtask

// One-cycle pulse on vs or bs, returns at the edge that samples it
task automatic pulse_sync(input logic vs_bit, input logic bs_bit);
    @(posedge LNK_CLK_IN);
    sync.vs <= vs_bit;
    sync.bs <= bs_bit;
    @(posedge LNK_CLK_IN);
    sync.vs <= 1'b0;
    sync.bs <= 1'b0;
endtask

task automatic start_video();
    @(posedge LNK_CLK_IN);
    vid_en <= 1'b1;
    pulse_sync(1'b1, 1'b0);
    repeat (32) @(posedge LNK_CLK_IN);     // Longest MSA read-out is over
endtask

task automatic stop_video();
    @(posedge LNK_CLK_IN);
    vid_en <= 1'b0;
    repeat (3) @(posedge LNK_CLK_IN);
endtask

task automatic apb_read_check(input logic [7:0] idx);
    msa_pkg::sym_t  rdata;
    logic           err;
    int             a;
    a = active_sublanes(lanes);
    apb_xfer(1'b0, idx, '0, rdata, err);
    check_value("apb_read_pslverr", 72'(idx >= 32 * a), 72'(err));
    if (idx < 32 * a)
        check_value("apb_read_data", 72'(ref_mem[idx % a][idx / a]), 72'(rdata));
endtask

function automatic msa_pkg::lnk_word_t bs_pair_word(input msa_pkg::sym_t s0,
                                                    input msa_pkg::sym_t s1);
    msa_pkg::lnk_word_t w;
    for (int l = 0; l < msa_pkg::lanes; l++)
    begin
        w[2 * l]     = s0;
        w[2 * l + 1] = s1;
    end
    return w;
endfunction

task automatic apb_readback_test();
    set_lanes(2'd3);
    for (int i = 0; i < 16; i++)
        apb_write(8'(i * 5), rand_sym());
    for (int i = 0; i < 16; i++)
        apb_read_check(8'(i * 5));
    // Index 64 with one lane would alias onto index 0
    set_lanes(2'd1);
    apb_write(8'd64, msa_pkg::sym_t'(~ref_mem[0][0]));
    apb_read_check(8'd0);
    apb_read_check(8'd200);
endtask

task automatic msa_readout_test(input string name, input msa_pkg::lane_cfg_t code, input int rows);
    msa_pkg::lnk_word_t exp;
    msa_pkg::lnk_word_t act;
    int                 a;
    set_lanes(code);
    a = active_sublanes(code);
    for (int i = 0; i < rows * a; i++)
        apb_write(8'(i), rand_sym());
    pulse_sync(1'b1, 1'b0);
    repeat (3) @(posedge LNK_CLK_IN);      // Row 0 follows the third edge
    for (int r = 0; r < rows; r++)
    begin
        @(negedge LNK_CLK_IN);
        exp = '0;
        act = '0;
        for (int s = 0; s < a; s++)
        begin
            exp[s] = ref_mem[s][r];
            act[s] = lnk_out[s];
        end
        check_value(name, exp, act);
    end
    @(negedge LNK_CLK_IN);
    check_value(name, '0, lnk_out);        // Read-out over, idle upstream link
endtask

task automatic bs_case(input string name, input logic efm_v, input logic running);
    msa_pkg::sym_t vb;
    vb.k   = 1'b0;
    vb.dat = running ? 8'h01 : msa_pkg::vbid_no_video;     // vbf held at 1
    @(posedge LNK_CLK_IN);
    efm <= efm_v;
    repeat (2) @(posedge LNK_CLK_IN);
    pulse_sync(1'b0, 1'b1);
    repeat (2) @(posedge LNK_CLK_IN);
    @(negedge LNK_CLK_IN);
    if (efm_v)
    begin
        check_value(name, bs_pair_word(msa_pkg::sym_bs, msa_pkg::sym_bf), lnk_out);
        @(negedge LNK_CLK_IN);
        check_value(name, bs_pair_word(msa_pkg::sym_bf, msa_pkg::sym_bs), lnk_out);
        @(negedge LNK_CLK_IN);
        check_value(name, bs_pair_word(vb, '0), lnk_out);
    end
    else
    begin
        check_value(name, bs_pair_word(msa_pkg::sym_bs, vb), lnk_out);
        @(negedge LNK_CLK_IN);
        check_value(name, bs_pair_word('0, '0), lnk_out);
    end
    @(negedge LNK_CLK_IN);
    check_value(name, '0, lnk_out);        // Idle upstream link again
endtask

task automatic bs_sequence_test();
    @(posedge LNK_CLK_IN);
    sync.vbf <= 1'b1;
    start_video();
    bs_case("bs_normal_run", 1'b0, 1'b1);
    bs_case("bs_enhanced_run", 1'b1, 1'b1);
    stop_video();
    bs_case("bs_normal_idle", 1'b0, 1'b0);
    bs_case("bs_enhanced_idle", 1'b1, 1'b0);
endtask

// Cycles until lane 0 shows the next BS symbol
task automatic wait_idle_bs(output int gap);
    gap = 0;
    do
    begin
        @(negedge LNK_CLK_IN);
        gap++;
    end
    while (lnk_out[0] !== msa_pkg::sym_bs && gap < 300);
    checks++;
    assert (lnk_out[0] === msa_pkg::sym_bs)
    else
    begin
        $display("No idle BS sequence seen within %0d cycles", gap);
        errors++;
    end
endtask

task automatic idle_bs_test();
    int gap;
    int seen;
    @(posedge LNK_CLK_IN);
    efm <= 1'b0;
    wait_idle_bs(gap);
    repeat (2)
    begin
        wait_idle_bs(gap);
        check_value("idle_bs_period", 72'd128, 72'(gap));
    end
    start_video();
    seen = 0;
    repeat (512)
    begin
        @(negedge LNK_CLK_IN);
        if (lnk_out[0] === msa_pkg::sym_bs)
            seen++;
    end
    check_value("idle_bs_running", 72'd0, 72'(seen));
endtask

task automatic pass_through_test();
    msa_pkg::lnk_word_t prev;
    msa_pkg::lnk_word_t cur;
    for (int s = 0; s < msa_pkg::sublanes; s++)
        prev[s] = rand_sym();
    @(posedge LNK_CLK_IN);
    lnk_in <= prev;
    for (int k = 0; k < 64; k++)
    begin
        for (int s = 0; s < msa_pkg::sublanes; s++)
            cur[s] = rand_sym();
        @(posedge LNK_CLK_IN);
        lnk_in <= cur;
        @(negedge LNK_CLK_IN);
        check_value("pass_through", prev, lnk_out);     // One cycle behind
        prev = cur;
    end
    @(posedge LNK_CLK_IN);
    lnk_in <= '0;
endtask

// ==== verif/msa_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module msa_tb;

localparam int clk_period  = 8;
localparam int idle_period = 256;       // Idle BS every 128 link cycles
// Cycles for APB, read-out, BS, idle and pass-through tests
localparam int run_cycles  = 150 + 650 + 100 + 1000 + 70;

logic                   LNK_RST_IN;
logic                   LNK_CLK_IN;
msa_pkg::lane_cfg_t     lanes;
logic                   vid_en;
logic                   efm;
msa_pkg::vid_sync_t     sync;
msa_pkg::apb_req_t      apb_req;
msa_pkg::apb_rsp_t      apb_rsp;
msa_pkg::lnk_word_t     lnk_in;
msa_pkg::lnk_word_t     lnk_out;

logic [31:0]            lfsr;
msa_pkg::sym_t          ref_mem [msa_pkg::sublanes][msa_pkg::ram_words];   // Bank, row
int                     checks;
int                     errors;

msa_top #(.P_IDLE_PERIOD (idle_period)) i_msa_top
(
    .LNK_RST_IN (LNK_RST_IN),
    .LNK_CLK_IN (LNK_CLK_IN),
    .lanes      (lanes),
    .vid_en     (vid_en),
    .efm        (efm),
    .sync       (sync),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .lnk_in     (lnk_in),
    .lnk_out    (lnk_out)
);

initial
begin
    LNK_CLK_IN = 1'b0;
    forever
        #(clk_period / 2) LNK_CLK_IN = ~LNK_CLK_IN;
end

// Watchdog with twice the expected run time
initial
begin
    #(2 * run_cycles * clk_period);
    $display("Timeout after %0d ns, the tests did not complete", 2 * run_cycles * clk_period);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("test failed");
    $finish;
end

// Galois LFSR, one step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++)
    begin
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        v    = {v[30:0], lfsr[0]};
    end
    return v;
endfunction

function automatic msa_pkg::sym_t rand_sym();
    logic [31:0] r;
    r = take_bits(9);
    return r[8:0];
endfunction

// Active sublanes for a lane code
function automatic int active_sublanes(input msa_pkg::lane_cfg_t code);
    case (code)
        2'd3    : return 8;
        2'd2    : return 4;
        default : return 2;
    endcase
endfunction

task automatic check_value(input string name, input logic [71:0] exp, input logic [71:0] act);
    checks++;
    assert (act === exp)
    else
    begin
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        errors++;
    end
endtask

// One APB transfer, setup then access
task automatic apb_xfer(input logic write, input logic [7:0] idx, input msa_pkg::sym_t wdata,
                        output msa_pkg::sym_t rdata, output logic err);
    @(posedge LNK_CLK_IN);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: idx, pwdata: wdata};
    @(posedge LNK_CLK_IN);
    apb_req.penable <= 1'b1;
    @(negedge LNK_CLK_IN);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check_value("apb_pready", 72'd1, 72'(apb_rsp.pready));     // Zero-wait slave
    @(posedge LNK_CLK_IN);
    apb_req <= '0;
endtask

// Write through APB and mirror it in the model
task automatic apb_write(input logic [7:0] idx, input msa_pkg::sym_t data);
    msa_pkg::sym_t  rdata;
    logic           err;
    int             a;
    a = active_sublanes(lanes);
    apb_xfer(1'b1, idx, data, rdata, err);
    check_value("apb_write_pslverr", 72'(idx >= 32 * a), 72'(err));
    if (idx < 32 * a)
        ref_mem[idx % a][idx / a] = data;
endtask

`include "msa_tb_tests.svh"

initial
begin
    LNK_RST_IN <= 1'b1;
    lanes      <= 2'd3;
    vid_en     <= 1'b0;
    efm        <= 1'b0;
    sync       <= '0;
    apb_req    <= '0;
    lnk_in     <= '0;
    lfsr   = 32'h54fe4ed9;
    checks = 0;
    errors = 0;
    repeat (4) @(posedge LNK_CLK_IN);
    LNK_RST_IN <= 1'b0;
    @(negedge LNK_CLK_IN);
    check_value("reset_pslverr", 72'd0, 72'(apb_rsp.pslverr));

    apb_readback_test();
    msa_readout_test("msa_4_lanes", 2'd3, 6);
    msa_readout_test("msa_2_lanes", 2'd2, 11);
    msa_readout_test("msa_1_lane", 2'd1, 20);
    bs_sequence_test();
    idle_bs_test();
    pass_through_test();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
        $display("test passed");
    else
        $display("test failed");
    $finish;
end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verif
common/msa_pkg.sv
msa_store/msa_apb_port.sv
msa_store/msa_symbol_ram.sv
src/blank_sequencer.sv
src/lane_mux.sv
src/msa_top.sv
verif/msa_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MSA inserter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f src.f --top-module msa_tb -o msa_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/msa_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
